// File: hw/fft_8pt.sv
`timescale 1ns/10ps

module fft_8pt #(
    parameter int BUS_W = 64
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           valid_i,
    input  logic [fft_pkg::N_PT*BUS_W-1:0] xi_re_i,
    input  logic [fft_pkg::N_PT*BUS_W-1:0] xi_im_i,
    input  logic [BUS_W-1:0]               w1_re_i,
    input  logic [BUS_W-1:0]               w1_im_i,
    input  logic [BUS_W-1:0]               w3_re_i,
    input  logic [BUS_W-1:0]               w3_im_i,
    output logic [fft_pkg::N_PT*BUS_W-1:0] xo_re_o,
    output logic [fft_pkg::N_PT*BUS_W-1:0] xo_im_o,
    output logic                           valid_o
);

    // stage one register outputs
    fft_pkg::sample_vec_t s1_re;
    fft_pkg::sample_vec_t s1_im;
    logic                 s1_valid;

    // combinational middle stage
    fft_pkg::sample_vec_t s2_re;
    fft_pkg::sample_vec_t s2_im;

    // ----------------------------------------
    // span-4 stage, first register
    // ----------------------------------------
    fft_stage1 #(
        .BUS_W (BUS_W)
    ) u_stage1 (
        .clk        (clk),
        .reset_n    (reset_n),
        .valid_i    (valid_i),
        .xi_re_i    (xi_re_i),
        .xi_im_i    (xi_im_i),
        .w1_re_i    (w1_re_i),
        .w1_im_i    (w1_im_i),
        .w3_re_i    (w3_re_i),
        .w3_im_i    (w3_im_i),
        .s1_re_o    (s1_re),
        .s1_im_o    (s1_im),
        .s1_valid_o (s1_valid)
    );

    fft_stage2 u_stage2 (
        .s1_re_i (s1_re),
        .s1_im_i (s1_im),
        .s2_re_o (s2_re),
        .s2_im_o (s2_im)
    );

    // span-1 stage and output register
    fft_stage3 #(
        .BUS_W (BUS_W)
    ) u_stage3 (
        .clk        (clk),
        .reset_n    (reset_n),
        .s2_re_i    (s2_re),
        .s2_im_i    (s2_im),
        .s1_valid_i (s1_valid),
        .xo_re_o    (xo_re_o),
        .xo_im_o    (xo_im_o),
        .valid_o    (valid_o)
    );

endmodule

// File: hw/fft_cmul.sv
`timescale 1ns/10ps

module fft_cmul (
    input  fft_pkg::sample_t a_re_i,
    input  fft_pkg::sample_t a_im_i,
    input  fft_pkg::sample_t w_re_i,
    input  fft_pkg::sample_t w_im_i,
    output fft_pkg::sample_t p_re_o,
    output fft_pkg::sample_t p_im_o
);

    localparam int PROD_W = 2 * fft_pkg::DATA_W;
    localparam int SLICE_HI = fft_pkg::DATA_W + fft_pkg::TW_FRAC - 1;

    logic signed [PROD_W-1:0] prod_ac;
    logic signed [PROD_W-1:0] prod_bd;
    logic signed [PROD_W-1:0] prod_ad;
    logic signed [PROD_W-1:0] prod_bc;
    logic signed [PROD_W-1:0] acc_re;
    logic signed [PROD_W-1:0] acc_im;

    // full precision signed products
    assign prod_ac = a_re_i * w_re_i;
    assign prod_bd = a_im_i * w_im_i;
    assign prod_ad = a_re_i * w_im_i;
    assign prod_bc = a_im_i * w_re_i;

    // (a + jb)(c + jd), wraps at PROD_W bits
    assign acc_re = prod_ac - prod_bd;
    assign acc_im = prod_ad + prod_bc;

    // drop the twiddle fraction bits and the top guard bits
    assign p_re_o = acc_re[SLICE_HI:fft_pkg::TW_FRAC];
    assign p_im_o = acc_im[SLICE_HI:fft_pkg::TW_FRAC];

endmodule

// File: hw/fft_pkg.sv
package fft_pkg;

    // ----------------------------------------
    // transform size and sample widths
    // ----------------------------------------
    localparam int N_PT = 8;

    // width carried between the stages and used for the twiddles
    localparam int DATA_W = 16;

    // bits taken from the top of each input slot
    localparam int IN_W = 17;

    // twiddles are signed Q3.12
    // product slice is [DATA_W+TW_FRAC-1:TW_FRAC]
    localparam int TW_FRAC = 12;

    // ----------------------------------------
    // sample types
    // ----------------------------------------
    typedef logic signed [DATA_W-1:0] sample_t;

    // stage one operands and sums
    typedef logic signed [IN_W-1:0] wide_t;

    // one component, real or imaginary, of all points
    typedef sample_t [N_PT-1:0] sample_vec_t;

endpackage

// File: hw/fft_stage1.sv
`timescale 1ns/10ps

module fft_stage1 #(
    parameter int BUS_W = 64
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           valid_i,
    input  logic [fft_pkg::N_PT*BUS_W-1:0] xi_re_i,
    input  logic [fft_pkg::N_PT*BUS_W-1:0] xi_im_i,
    input  logic [BUS_W-1:0]               w1_re_i,
    input  logic [BUS_W-1:0]               w1_im_i,
    input  logic [BUS_W-1:0]               w3_re_i,
    input  logic [BUS_W-1:0]               w3_im_i,
    output fft_pkg::sample_vec_t           s1_re_o,
    output fft_pkg::sample_vec_t           s1_im_o,
    output logic                           s1_valid_o
);

    localparam int HALF = fft_pkg::N_PT / 2;

    fft_pkg::wide_t       in_re   [fft_pkg::N_PT];
    fft_pkg::wide_t       in_im   [fft_pkg::N_PT];
    fft_pkg::sample_t     half_re [fft_pkg::N_PT];
    fft_pkg::sample_t     half_im [fft_pkg::N_PT];
    fft_pkg::sample_t     w1_re;
    fft_pkg::sample_t     w1_im;
    fft_pkg::sample_t     w3_re;
    fft_pkg::sample_t     w3_im;
    fft_pkg::sample_t     w1_p_re;
    fft_pkg::sample_t     w1_p_im;
    fft_pkg::sample_t     w3_p_re;
    fft_pkg::sample_t     w3_p_im;
    fft_pkg::sample_vec_t rot_re;
    fft_pkg::sample_vec_t rot_im;

    // ----------------------------------------
    // input unpacking
    // ----------------------------------------
    for (genvar n = 0; n < fft_pkg::N_PT; n++) begin : g_unpack
        assign in_re[n] = xi_re_i[n*BUS_W+BUS_W-1 -: fft_pkg::IN_W];
        assign in_im[n] = xi_im_i[n*BUS_W+BUS_W-1 -: fft_pkg::IN_W];
    end

    // twiddles sit in the top bits of their buses
    assign w1_re = w1_re_i[BUS_W-1 -: fft_pkg::DATA_W];
    assign w1_im = w1_im_i[BUS_W-1 -: fft_pkg::DATA_W];
    assign w3_re = w3_re_i[BUS_W-1 -: fft_pkg::DATA_W];
    assign w3_im = w3_im_i[BUS_W-1 -: fft_pkg::DATA_W];

    // ----------------------------------------
    // span-4 butterflies
    // ----------------------------------------
    for (genvar n = 0; n < HALF; n++) begin : g_bfly
        fft_pkg::wide_t sum_re;
        fft_pkg::wide_t sum_im;
        fft_pkg::wide_t dif_re;
        fft_pkg::wide_t dif_im;

        assign sum_re = in_re[n] + in_re[n+HALF];
        assign sum_im = in_im[n] + in_im[n+HALF];
        assign dif_re = in_re[n] - in_re[n+HALF];
        assign dif_im = in_im[n] - in_im[n+HALF];

        // halve by dropping the lsb
        assign half_re[n]      = sum_re[fft_pkg::IN_W-1:1];
        assign half_im[n]      = sum_im[fft_pkg::IN_W-1:1];
        assign half_re[n+HALF] = dif_re[fft_pkg::IN_W-1:1];
        assign half_im[n+HALF] = dif_im[fft_pkg::IN_W-1:1];
    end

    // item 5 by W1, item 7 by W3
    fft_cmul u_cmul_w1 (
        .a_re_i (half_re[5]),
        .a_im_i (half_im[5]),
        .w_re_i (w1_re),
        .w_im_i (w1_im),
        .p_re_o (w1_p_re),
        .p_im_o (w1_p_im)
    );

    fft_cmul u_cmul_w3 (
        .a_re_i (half_re[7]),
        .a_im_i (half_im[7]),
        .w_re_i (w3_re),
        .w_im_i (w3_im),
        .p_re_o (w3_p_re),
        .p_im_o (w3_p_im)
    );

    always_comb begin
        // sums and item 4 (W0) pass straight through
        for (int n = 0; n <= HALF; n++) begin
            rot_re[n] = half_re[n];
            rot_im[n] = half_im[n];
        end
        rot_re[5] = w1_p_re;
        rot_im[5] = w1_p_im;
        // W2 is -j, so swap and negate
        rot_re[6] = half_im[6];
        rot_im[6] = -half_re[6];
        rot_re[7] = w3_p_re;
        rot_im[7] = w3_p_im;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1_re_o    <= '0;
            s1_im_o    <= '0;
            s1_valid_o <= 1'b0;
        end else begin
            s1_re_o    <= rot_re;
            s1_im_o    <= rot_im;
            s1_valid_o <= valid_i;
        end
    end

endmodule

// File: hw/fft_stage2.sv
`timescale 1ns/10ps

module fft_stage2 (
    input  fft_pkg::sample_vec_t s1_re_i,
    input  fft_pkg::sample_vec_t s1_im_i,
    output fft_pkg::sample_vec_t s2_re_o,
    output fft_pkg::sample_vec_t s2_im_o
);

    // butterflies pair n with n+SPAN inside each group of GROUP items
    localparam int SPAN  = 2;
    localparam int GROUP = 2 * SPAN;

    fft_pkg::sample_t bf_re [fft_pkg::N_PT];
    fft_pkg::sample_t bf_im [fft_pkg::N_PT];

    // ----------------------------------------
    // span-2 butterflies, 16 bit wrap
    // ----------------------------------------
    always_comb begin
        for (int g = 0; g < fft_pkg::N_PT; g += GROUP) begin
            for (int k = 0; k < SPAN; k++) begin
                bf_re[g+k]      = s1_re_i[g+k] + s1_re_i[g+k+SPAN];
                bf_im[g+k]      = s1_im_i[g+k] + s1_im_i[g+k+SPAN];
                bf_re[g+k+SPAN] = s1_re_i[g+k] - s1_re_i[g+k+SPAN];
                bf_im[g+k+SPAN] = s1_im_i[g+k] - s1_im_i[g+k+SPAN];
            end
        end
    end

    // last item of each group takes the -j rotation
    always_comb begin
        for (int n = 0; n < fft_pkg::N_PT; n++) begin
            if (n % GROUP == GROUP - 1) begin
                s2_re_o[n] = bf_im[n];
                s2_im_o[n] = -bf_re[n];
            end else begin
                s2_re_o[n] = bf_re[n];
                s2_im_o[n] = bf_im[n];
            end
        end
    end

endmodule

// File: hw/fft_stage3.sv
`timescale 1ns/10ps

module fft_stage3 #(
    parameter int BUS_W = 64
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  fft_pkg::sample_vec_t           s2_re_i,
    input  fft_pkg::sample_vec_t           s2_im_i,
    input  logic                           s1_valid_i,
    output logic [fft_pkg::N_PT*BUS_W-1:0] xo_re_o,
    output logic [fft_pkg::N_PT*BUS_W-1:0] xo_im_o,
    output logic                           valid_o
);

    localparam int PAD_W = BUS_W - fft_pkg::DATA_W;

    fft_pkg::sample_vec_t bf_re;
    fft_pkg::sample_vec_t bf_im;
    fft_pkg::sample_vec_t res_re;
    fft_pkg::sample_vec_t res_im;

    // ----------------------------------------
    // span-1 butterflies
    // ----------------------------------------
    // sum to the even slot, difference to the odd slot
    always_comb begin
        for (int m = 0; m < fft_pkg::N_PT; m += 2) begin
            bf_re[m]   = s2_re_i[m] + s2_re_i[m+1];
            bf_im[m]   = s2_im_i[m] + s2_im_i[m+1];
            bf_re[m+1] = s2_re_i[m] - s2_re_i[m+1];
            bf_im[m+1] = s2_im_i[m] - s2_im_i[m+1];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            res_re  <= '0;
            res_im  <= '0;
            valid_o <= 1'b0;
        end else begin
            res_re  <= bf_re;
            res_im  <= bf_im;
            valid_o <= s1_valid_i;
        end
    end

    // ----------------------------------------
    // output packing
    // ----------------------------------------
    // results stay in bit-reversed order, left aligned in each slot
    for (genvar n = 0; n < fft_pkg::N_PT; n++) begin : g_pack
        assign xo_re_o[n*BUS_W +: BUS_W] = {res_re[n], {PAD_W{1'b0}}};
        assign xo_im_o[n*BUS_W +: BUS_W] = {res_im[n], {PAD_W{1'b0}}};
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the FFT testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f sim.f --top-module tb_fft_8pt -o sim_fft \
    && ./obj_dir/sim_fft | tee /dev/stderr | grep -q "^test passed$" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

// File: sim.f
hw/fft_pkg.sv
hw/fft_cmul.sv
hw/fft_stage1.sv
hw/fft_stage2.sv
hw/fft_stage3.sv
hw/fft_8pt.sv
testbench/fft_8pt_assert.sv
testbench/tb_fft_8pt.sv

// File: testbench/fft_8pt_assert.sv
`timescale 1ns/10ps

module fft_8pt_assert #(
    parameter int BUS_W = 64
) (
    input logic                           clk,
    input logic                           reset_n,
    input logic                           valid_i,
    input logic                           valid_o,
    input logic [fft_pkg::N_PT*BUS_W-1:0] xo_re_o,
    input logic [fft_pkg::N_PT*BUS_W-1:0] xo_im_o
);

    localparam int PAD_W = BUS_W - fft_pkg::DATA_W;

    // valid travels two register stages
    a_valid_delay: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n, 1) && $past(reset_n, 2) |-> valid_o == $past(valid_i, 2))
        else $error("valid_o does not follow valid_i by two cycles");

    a_valid_after_reset: assert property (@(posedge clk) !$past(reset_n) |-> !valid_o)
        else $error("valid_o high on the cycle after reset");

    // results sit at the top of each slot
    for (genvar n = 0; n < fft_pkg::N_PT; n++) begin : g_pad
        a_pad_zero: assert property (@(posedge clk)
            xo_re_o[n*BUS_W +: PAD_W] == '0 && xo_im_o[n*BUS_W +: PAD_W] == '0)
            else $error("low bits of output slot %0d are not zero", n);
    end

endmodule

// File: testbench/tb_fft_8pt.sv
`timescale 1ns/10ps

module tb_fft_8pt;

    localparam int BUS_W = 64;
    localparam int N_RAND = 200;
    localparam int N_GAP = 200;
    localparam int MAX_CYCLES = 3 + 1 + N_RAND + N_GAP + 20;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         valid_i;
    logic [511:0] xi_re_i;
    logic [511:0] xi_im_i;
    logic [63:0]  w1_re_i;
    logic [63:0]  w1_im_i;
    logic [63:0]  w3_re_i;
    logic [63:0]  w3_im_i;
    logic [511:0] xo_re_o;
    logic [511:0] xo_im_o;
    logic         valid_o;

    // next input set, filled before each drive
    logic [511:0] nx_re;
    logic [511:0] nx_im;
    logic [63:0]  nw1_re;
    logic [63:0]  nw1_im;
    logic [63:0]  nw3_re;
    logic [63:0]  nw3_im;

    // expected results, two deep
    logic [127:0] q_re[$];
    logic [127:0] q_im[$];
    bit           q_v[$];
    string        q_name[$];

    string        test_name;
    integer       seed;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;

    fft_8pt #(
        .BUS_W (BUS_W)
    ) u_fft_8pt (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (valid_i),
        .xi_re_i (xi_re_i),
        .xi_im_i (xi_im_i),
        .w1_re_i (w1_re_i),
        .w1_im_i (w1_im_i),
        .w3_re_i (w3_re_i),
        .w3_im_i (w3_im_i),
        .xo_re_o (xo_re_o),
        .xo_im_o (xo_im_o),
        .valid_o (valid_o)
    );

    bind fft_8pt fft_8pt_assert #(.BUS_W(BUS_W)) u_assert (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // reference model of the three stages
    // ----------------------------------------
    task automatic model_fft(output logic [127:0] er, output logic [127:0] ei);
        logic signed [16:0] a_re [8];
        logic signed [16:0] a_im [8];
        logic signed [16:0] t;
        logic signed [15:0] h_re [8];
        logic signed [15:0] h_im [8];
        logic signed [15:0] wr;
        logic signed [15:0] wi;
        logic signed [31:0] pr;
        logic signed [31:0] pi;
        logic signed [15:0] b_re [8];
        logic signed [15:0] b_im [8];
        logic signed [15:0] tmp;
        for (int n = 0; n < 8; n++) begin
            a_re[n] = nx_re[n*64+63 -: 17];
            a_im[n] = nx_im[n*64+63 -: 17];
        end
        for (int n = 0; n < 4; n++) begin
            t = a_re[n] + a_re[n+4];
            h_re[n] = t[16:1];
            t = a_im[n] + a_im[n+4];
            h_im[n] = t[16:1];
            t = a_re[n] - a_re[n+4];
            h_re[n+4] = t[16:1];
            t = a_im[n] - a_im[n+4];
            h_im[n+4] = t[16:1];
        end
        // twiddle products on items 5 and 7
        for (int k = 5; k < 8; k += 2) begin
            wr = (k == 5) ? nw1_re[63:48] : nw3_re[63:48];
            wi = (k == 5) ? nw1_im[63:48] : nw3_im[63:48];
            pr = h_re[k] * wr;
            pr = pr - h_im[k] * wi;
            pi = h_re[k] * wi;
            pi = pi + h_im[k] * wr;
            h_re[k] = pr[27:12];
            h_im[k] = pi[27:12];
        end
        tmp = h_re[6];
        h_re[6] = h_im[6];
        h_im[6] = -tmp;
        for (int g = 0; g < 8; g += 4) begin
            for (int k = 0; k < 2; k++) begin
                b_re[g+k] = h_re[g+k] + h_re[g+k+2];
                b_im[g+k] = h_im[g+k] + h_im[g+k+2];
                b_re[g+k+2] = h_re[g+k] - h_re[g+k+2];
                b_im[g+k+2] = h_im[g+k] - h_im[g+k+2];
            end
            tmp = b_re[g+3];
            b_re[g+3] = b_im[g+3];
            b_im[g+3] = -tmp;
        end
        for (int m = 0; m < 8; m += 2) begin
            er[m*16 +: 16] = b_re[m] + b_re[m+1];
            ei[m*16 +: 16] = b_im[m] + b_im[m+1];
            er[(m+1)*16 +: 16] = b_re[m] - b_re[m+1];
            ei[(m+1)*16 +: 16] = b_im[m] - b_im[m+1];
        end
    endtask

    task automatic check_front();
        logic [127:0] er;
        logic [127:0] ei;
        bit           ev;
        string        nm;
        if (q_v.size() == 2) begin
            er = q_re.pop_front();
            ei = q_im.pop_front();
            ev = q_v.pop_front();
            nm = q_name.pop_front();
            checks++;
            if (valid_o !== ev) begin
                $display("FAILED %s valid_o expected %0b actual %0b", nm, ev, valid_o);
                errors++;
            end
            for (int n = 0; n < 8; n++) begin
                if (ev && xo_re_o[n*64+48 +: 16] !== er[n*16 +: 16]) begin
                    $display("FAILED %s re[%0d] expected %h actual %h", nm, n,
                             er[n*16 +: 16], xo_re_o[n*64+48 +: 16]);
                    errors++;
                end
                if (ev && xo_im_o[n*64+48 +: 16] !== ei[n*16 +: 16]) begin
                    $display("FAILED %s im[%0d] expected %h actual %h", nm, n,
                             ei[n*16 +: 16], xo_im_o[n*64+48 +: 16]);
                    errors++;
                end
                if (xo_re_o[n*64 +: 48] !== 48'd0 || xo_im_o[n*64 +: 48] !== 48'd0) begin
                    $display("FAILED %s pad[%0d] expected 0 actual %h %h", nm, n,
                             xo_re_o[n*64 +: 48], xo_im_o[n*64 +: 48]);
                    errors++;
                end
            end
        end
    endtask

    // check the outputs due now, then present the next set
    task automatic drive_set(input bit vld);
        logic [127:0] er;
        logic [127:0] ei;
        @(negedge clk);
        check_front();
        valid_i = vld;
        xi_re_i = nx_re;
        xi_im_i = nx_im;
        w1_re_i = nw1_re;
        w1_im_i = nw1_im;
        w3_re_i = nw3_re;
        w3_im_i = nw3_im;
        model_fft(er, ei);
        q_re.push_back(er);
        q_im.push_back(ei);
        q_v.push_back(vld);
        q_name.push_back(test_name);
    endtask

    task automatic randomize_inputs();
        for (int n = 0; n < 8; n++) begin
            nx_re[n*64 +: 64] = {$random(seed), $random(seed)};
            nx_im[n*64 +: 64] = {$random(seed), $random(seed)};
        end
        nw1_re = {$random(seed), $random(seed)};
        nw1_im = {$random(seed), $random(seed)};
        nw3_re = {$random(seed), $random(seed)};
        nw3_im = {$random(seed), $random(seed)};
    endtask

    task automatic check_idle();
        checks++;
        if (valid_o !== 1'b0) begin
            $display("FAILED %s valid_o expected 0 actual %0b", test_name, valid_o);
            errors++;
        end
        if (xo_re_o !== '0 || xo_im_o !== '0) begin
            $display("FAILED %s outputs expected 0 actual re %h im %h",
                     test_name, xo_re_o, xo_im_o);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 32'hc0a5;
        randomize_inputs();
        reset_n = 1'b0;
        // live data during reset must not reach the outputs
        valid_i = 1'b1;
        xi_re_i = nx_re;
        xi_im_i = nx_im;
        w1_re_i = nw1_re;
        w1_im_i = nw1_im;
        w3_re_i = nw3_re;
        w3_im_i = nw3_im;
        test_name = "reset";
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        reset_n = 1'b1;
        valid_i = 1'b0;
        @(negedge clk);
        check_idle();

        // impulse on x0 with 45 degree twiddles
        test_name = "impulse";
        nx_re = '0;
        nx_im = '0;
        nx_re[63:0] = {17'h0a5a4, 47'd0};
        nw1_re = {16'sd2896, 48'd0};
        nw1_im = {-16'sd2896, 48'd0};
        nw3_re = {16'sd2896, 48'd0};
        nw3_im = {-16'sd2896, 48'd0};
        drive_set(1'b1);

        test_name = "random";
        repeat (N_RAND) begin
            randomize_inputs();
            drive_set(1'b1);
        end

        test_name = "valid_gaps";
        repeat (N_GAP) begin
            randomize_inputs();
            r = $random(seed);
            drive_set(r[0]);
        end

        // drain the pipeline
        test_name = "drain";
        drive_set(1'b0);
        drive_set(1'b0);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
